//--- i2c_proto_pkg.sv
/* bus framing constants, slave address, bus phase type and phase lengths
   for the I2C master */
package i2c_proto_pkg;

    // ********************
    // device and bit timing
    localparam logic [6:0] SLAVE_ADDR    = 7'b1010000;   // EEPROM base address
    localparam int         TICKS_PER_BIT = 4;            // dri_clk cycles per scl bit
    localparam int         BYTE_BITS     = 8;

    // ********************
    // phase lengths in dri_clk cycles
    localparam int ADDR_PHASE_LEN = 40;   // lead-in + 8 bits + ack
    localparam int BYTE_PHASE_LEN = 36;   // 8 bits + ack
    localparam int STOP_PHASE_LEN = 17;

    // one phase per byte on the wire, plus the stop
    typedef enum logic [2:0] {
        PH_START_BYTE,      // start, then byte
        PH_RESTART_BYTE,    // repeated start, then byte
        PH_WRITE_BYTE,      // byte, slave ack
        PH_READ_BYTE,       // receive byte, master nack
        PH_STOP
    } phase_t;

endpackage

//--- i2c_req_pkg.sv
/* user request types: word address, data byte and read/write bit values */
package i2c_req_pkg;

    typedef logic [15:0] word_addr_t;   // 16b or 8b used, see bit_ctrl
    typedef logic [7:0]  data_byte_t;

    // ********************
    // r/w bit after the slave address
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

endpackage

//--- i2c_xfer_if.sv
`timescale 1ns/1ps
/* phase handshake and byte path between sequencer, bit engine and shifter */
interface i2c_xfer_if;

    i2c_proto_pkg::phase_t   phase;
    logic                    go;        // starts one phase
    logic                    load;      // shifter load, with go
    logic                    done;      // last cycle but one of a phase
    logic                    shift;     // tx bit consumed
    logic                    sample;    // scl rise while reading
    logic                    tx_bit;
    i2c_req_pkg::data_byte_t tx_byte;
    i2c_req_pkg::data_byte_t rx_byte;

    modport ctrl (output phase, go, load, tx_byte, input done, rx_byte);

    modport engine (input phase, go, tx_bit, output done, shift, sample);

    modport shifter (input load, tx_byte, shift, sample, output tx_bit, rx_byte);

endinterface

//--- i2c_seq_ctrl.sv
`timescale 1ns/1ps
/* transaction sequencer: request latch, state walk, phase and byte selection,
   read data and done registers */
module i2c_seq_ctrl (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  logic                    i2c_exec,
    input  logic                    bit_ctrl,
    input  logic                    i2c_rh_wl,
    input  i2c_req_pkg::word_addr_t i2c_addr,
    input  i2c_req_pkg::data_byte_t i2c_data_w,
    output i2c_req_pkg::data_byte_t i2c_data_r,
    output logic                    i2c_done,
    i2c_xfer_if.ctrl                xfer
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SLADDR,
        ST_ADDR16,
        ST_ADDR8,
        ST_DATA_WR,
        ST_ADDR_RD,
        ST_DATA_RD,
        ST_STOP
    } state_t;

    state_t                  st;
    state_t                  tgt;          // state whose phase is being launched
    logic                    start;
    logic                    go_q;
    logic                    rd_q;         // 1: random read
    logic                    wide_q;       // 1: 16-bit word address
    logic                    phase_open;
    i2c_req_pkg::word_addr_t addr_q;
    i2c_req_pkg::data_byte_t data_q;

    assign start     = (st == ST_IDLE) && i2c_exec;
    assign tgt       = (st == ST_IDLE) ? ST_SLADDR : st;
    assign xfer.go   = start || go_q;
    assign xfer.load = xfer.go;

    // ********************
    // phase kind and byte per state
    always_comb begin
        xfer.phase   = i2c_proto_pkg::PH_WRITE_BYTE;
        xfer.tx_byte = '0;
        case (tgt)
            ST_SLADDR: begin
                xfer.phase   = i2c_proto_pkg::PH_START_BYTE;
                xfer.tx_byte = {i2c_proto_pkg::SLAVE_ADDR, i2c_req_pkg::RW_WRITE};
            end
            ST_ADDR16:  xfer.tx_byte = addr_q[15:8];
            ST_ADDR8:   xfer.tx_byte = addr_q[7:0];
            ST_DATA_WR: xfer.tx_byte = data_q;
            ST_ADDR_RD: begin
                xfer.phase   = i2c_proto_pkg::PH_RESTART_BYTE;
                xfer.tx_byte = {i2c_proto_pkg::SLAVE_ADDR, i2c_req_pkg::RW_READ};
            end
            ST_DATA_RD: xfer.phase = i2c_proto_pkg::PH_READ_BYTE;
            ST_STOP:    xfer.phase = i2c_proto_pkg::PH_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge dri_clk) begin
        if (start) begin
            addr_q <= i2c_addr;
            data_q <= i2c_data_w;
        end
    end

    // ********************
    // state walk
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            st         <= ST_IDLE;
            go_q       <= 1'b0;
            rd_q       <= 1'b0;
            wide_q     <= 1'b0;
            i2c_data_r <= '0;
            i2c_done   <= 1'b0;
        end else begin
            go_q     <= xfer.done && (st != ST_STOP);   // next phase back to back
            i2c_done <= xfer.done && (st == ST_STOP);
            if (start) begin
                st     <= ST_SLADDR;
                rd_q   <= i2c_rh_wl;
                wide_q <= bit_ctrl;
            end else if (xfer.done) begin
                case (st)
                    ST_SLADDR:  st <= wide_q ? ST_ADDR16 : ST_ADDR8;
                    ST_ADDR16:  st <= ST_ADDR8;
                    ST_ADDR8:   st <= rd_q ? ST_ADDR_RD : ST_DATA_WR;
                    ST_DATA_WR: st <= ST_STOP;
                    ST_ADDR_RD: st <= ST_DATA_RD;
                    ST_DATA_RD: begin
                        st         <= ST_STOP;
                        i2c_data_r <= xfer.rx_byte;
                    end
                    default:    st <= ST_IDLE;
                endcase
            end
        end
    end

    // open from go until the engine reports done
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_open <= 1'b0;
        end else if (xfer.go) begin
            phase_open <= 1'b1;
        end else if (xfer.done) begin
            phase_open <= 1'b0;
        end
    end

    a_go_between_phases: assert property (@(posedge dri_clk) disable iff (!rst_n)
        xfer.go |-> !phase_open);

    a_done_single: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done);

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/1ps
/* scl/sda waveform generator: start and restart lead-in, bit slots,
   ack or nack slot, stop, and the phase strobes */
module i2c_bit_engine (
    input  logic       dri_clk,
    input  logic       rst_n,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_dir,
    i2c_xfer_if.engine xfer
);

    i2c_proto_pkg::phase_t cur_ph;   // latched on go
    logic                  active;
    logic [5:0]            cnt;
    logic [5:0]            len;
    logic [5:0]            rel;      // count from the first data bit
    logic [5:0]            slot;     // position inside one bit
    logic                  has_lead;
    logic                  in_lead;
    logic                  in_bits;
    logic                  reading;

    assign has_lead = (cur_ph == i2c_proto_pkg::PH_START_BYTE) ||
                      (cur_ph == i2c_proto_pkg::PH_RESTART_BYTE);
    assign reading  = (cur_ph == i2c_proto_pkg::PH_READ_BYTE);

    always_comb begin
        if (cur_ph == i2c_proto_pkg::PH_STOP) begin
            len = 6'(i2c_proto_pkg::STOP_PHASE_LEN);
        end else if (has_lead) begin
            len = 6'(i2c_proto_pkg::ADDR_PHASE_LEN);
        end else begin
            len = 6'(i2c_proto_pkg::BYTE_PHASE_LEN);
        end
    end

    assign rel     = has_lead ? cnt - 6'(i2c_proto_pkg::ADDR_PHASE_LEN
                                     - i2c_proto_pkg::BYTE_PHASE_LEN) : cnt;
    assign in_lead = has_lead && (cnt < 6'(i2c_proto_pkg::ADDR_PHASE_LEN
                                         - i2c_proto_pkg::BYTE_PHASE_LEN));
    assign slot    = rel % 6'(i2c_proto_pkg::TICKS_PER_BIT);
    assign in_bits = active && !in_lead && (cur_ph != i2c_proto_pkg::PH_STOP) &&
                     (rel < 6'(i2c_proto_pkg::BYTE_BITS * i2c_proto_pkg::TICKS_PER_BIT));

    // ********************
    // strobes
    assign xfer.done   = active && (cnt == len - 6'd2);
    assign xfer.shift  = in_bits && !reading && (slot == 6'd3);   // on scl fall
    assign xfer.sample = in_bits && reading && (slot == 6'd2);    // scl just high

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_ph  <= i2c_proto_pkg::PH_STOP;
            active  <= 1'b0;
            cnt     <= '0;
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_dir <= 1'b1;
        end else begin
            if (xfer.go) begin
                cur_ph <= xfer.phase;
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 6'd1;
                if (cnt == len - 6'd1) begin
                    active <= 1'b0;
                end
            end

            if (active) begin
                if (cur_ph == i2c_proto_pkg::PH_STOP) begin
                    case (cnt)
                        6'd0: begin
                            sda_dir <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        6'd1: scl     <= 1'b1;
                        6'd3: sda_out <= 1'b1;   // stop: sda rises, scl high
                        default: ;
                    endcase
                end else if (in_lead) begin
                    case (cnt)
                        6'd0: begin
                            sda_dir <= 1'b1;
                            sda_out <= 1'b1;
                        end
                        6'd1: scl     <= 1'b1;
                        6'd2: sda_out <= 1'b0;   // (re)start
                        6'd3: scl     <= 1'b0;
                        default: ;
                    endcase
                end else begin
                    case (slot)
                        6'd0: begin
                            if (!in_bits) begin      // ninth bit
                                sda_dir <= reading;  // nack when reading, else release
                                sda_out <= 1'b1;
                            end else if (reading) begin
                                sda_dir <= 1'b0;
                            end else begin
                                sda_dir <= 1'b1;
                                sda_out <= xfer.tx_bit;
                            end
                        end
                        6'd1: scl <= 1'b1;
                        6'd3: scl <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    a_no_joint_edge: assert property (@(posedge dri_clk) disable iff (!rst_n)
        in_bits |=> !($changed(scl) && $changed(sda_out)));

endmodule

//--- i2c_byte_shifter.sv
`timescale 1ns/1ps
/* transmit and receive shift registers */
module i2c_byte_shifter (
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        sda_in,
    i2c_xfer_if.shifter xfer
);

    i2c_req_pkg::data_byte_t tx_sr;
    i2c_req_pkg::data_byte_t rx_sr;

    // ********************
    // msb first on the wire
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr <= '0;
            rx_sr <= '0;
        end else begin
            if (xfer.load) begin
                tx_sr <= xfer.tx_byte;
            end else if (xfer.shift) begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
            if (xfer.sample) begin
                rx_sr <= {rx_sr[6:0], sda_in};
            end
        end
    end

    assign xfer.tx_bit  = tx_sr[7];
    assign xfer.rx_byte = rx_sr;

    a_tx_rx_exclusive: assert property (@(posedge dri_clk) disable iff (!rst_n)
        !(xfer.shift && xfer.sample));

endmodule

//--- i2c_master_top.sv
`timescale 1ns/1ps
/* I2C master top level: sda tri-state driver and sub-module instances */
module i2c_master_top (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  logic                    i2c_exec,
    input  logic                    bit_ctrl,
    input  logic                    i2c_rh_wl,
    input  i2c_req_pkg::word_addr_t i2c_addr,
    input  i2c_req_pkg::data_byte_t i2c_data_w,
    output i2c_req_pkg::data_byte_t i2c_data_r,
    output logic                    i2c_done,
    output logic                    scl,
    inout  wire                     sda
);

    logic sda_out;
    logic sda_dir;   // 1: master drives sda
    logic sda_in;

    i2c_xfer_if xfer ();

    assign sda    = sda_dir ? sda_out : 1'bz;
    assign sda_in = sda;

    i2c_seq_ctrl u_seq_ctrl (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .xfer       (xfer)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_dir (sda_dir),
        .xfer    (xfer)
    );

    i2c_byte_shifter u_byte_shifter (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .sda_in  (sda_in),
        .xfer    (xfer)
    );

endmodule

//--- i2c_slave_model.sv
`timescale 1ns/1ps
/* behavioral EEPROM slave: start and stop detect, address match, ack,
   word address pointer, memory write and read, address byte report */
module i2c_slave_model (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       addr16,      // two word address bytes
    input  logic       scl,
    inout  wire        sda,
    output logic       addr_stb,
    output logic [7:0] addr_byte,
    output logic       addr_rs      // byte came after a repeated start
);

    logic [7:0]  mem [256];
    logic [15:0] ptr;
    logic [7:0]  rx_sr;
    logic [7:0]  tx_sr;
    logic [3:0]  bit_cnt;          // scl rises in the current byte
    logic [1:0]  byte_cnt;         // bytes since start, saturates
    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic        restart;
    logic        selected;
    logic        rd_mode;
    logic        sending;
    logic        mack;
    logic        drive_low;
    logic        is_start;
    logic        is_stop;

    assign sda      = drive_low ? 1'b0 : 1'bz;
    assign is_start = scl && scl_q && sda_q && !sda;
    assign is_stop  = scl && scl_q && !sda_q && sda;

    always @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = 8'(i) ^ 8'h5a;
            end
            ptr       <= '0;
            rx_sr     <= '0;
            tx_sr     <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            in_frame  <= 1'b0;
            restart   <= 1'b0;
            selected  <= 1'b0;
            rd_mode   <= 1'b0;
            sending   <= 1'b0;
            mack      <= 1'b0;
            drive_low <= 1'b0;
            addr_stb  <= 1'b0;
            addr_byte <= '0;
            addr_rs   <= 1'b0;
        end else begin
            scl_q    <= scl;
            sda_q    <= sda;
            addr_stb <= 1'b0;
            if (is_start) begin
                restart   <= in_frame;
                in_frame  <= 1'b1;
                rd_mode   <= 1'b0;
                sending   <= 1'b0;
                drive_low <= 1'b0;
                bit_cnt   <= '0;
                byte_cnt  <= '0;
            end else if (is_stop) begin
                in_frame  <= 1'b0;
                selected  <= 1'b0;
                sending   <= 1'b0;
                drive_low <= 1'b0;
                bit_cnt   <= '0;
            end else if (in_frame && scl && !scl_q) begin
                if (bit_cnt < 4'd8) begin
                    rx_sr   <= {rx_sr[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= 4'd9;
                    mack    <= !sda;                  // master ack while reading
                end
            end else if (in_frame && !scl && scl_q) begin
                if (bit_cnt == 4'd8 && sending) begin
                    drive_low <= 1'b0;                // master answers
                end else if (bit_cnt == 4'd8) begin
                    if (byte_cnt != 2'd3) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                    if (byte_cnt == 2'd0) begin
                        selected  <= (rx_sr[7:1] == i2c_proto_pkg::SLAVE_ADDR);
                        rd_mode   <= rx_sr[0];
                        drive_low <= (rx_sr[7:1] == i2c_proto_pkg::SLAVE_ADDR);
                        addr_stb  <= 1'b1;
                        addr_byte <= rx_sr;
                        addr_rs   <= restart;
                    end else begin
                        drive_low <= selected;
                        if (byte_cnt < (addr16 ? 2'd3 : 2'd2)) begin
                            ptr <= {ptr[7:0], rx_sr};     // word address bytes
                        end else if (selected) begin
                            mem[ptr[7:0]] = rx_sr;
                            ptr <= ptr + 16'd1;
                        end
                    end
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt <= '0;
                    if (selected && rd_mode && (!sending || mack)) begin
                        tx_sr     <= {mem[ptr[7:0]][6:0], 1'b0};
                        drive_low <= !mem[ptr[7:0]][7];
                        ptr       <= ptr + 16'd1;
                        sending   <= 1'b1;
                    end else begin
                        drive_low <= 1'b0;
                        sending   <= 1'b0;
                    end
                end else if (sending && bit_cnt != 4'd0) begin
                    drive_low <= !tx_sr[7];
                    tx_sr     <= {tx_sr[6:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- tb_i2c_master.sv
`timescale 1ns/1ps
/* testbench for the I2C master: clock, reset, LCG stimulus, EEPROM slave,
   protocol and data assertions, closing report */
module tb_i2c_master;

    localparam int          DRV_DLY    = 10;
    localparam int          DONE_LIMIT = 400;   // longest frame is 205 cycles
    localparam logic [31:0] SEED       = 32'h755fff0b;

    logic                    dri_clk;
    logic                    rst_n;
    logic                    i2c_exec;
    logic                    bit_ctrl;
    logic                    i2c_rh_wl;
    i2c_req_pkg::word_addr_t i2c_addr;
    i2c_req_pkg::data_byte_t i2c_data_w;
    i2c_req_pkg::data_byte_t i2c_data_r;
    logic                    i2c_done;
    logic                    scl;
    wire                     sda;

    logic       addr_stb;
    logic [7:0] addr_byte;
    logic       addr_rs;

    // transaction under test
    string                   test_name;
    logic                    started;
    logic                    exp_rd;
    i2c_req_pkg::data_byte_t exp_data;
    int                      err_cnt;
    int                      tmo_cnt;
    logic [31:0]             rng;
    i2c_req_pkg::word_addr_t wr_addr [8];
    i2c_req_pkg::data_byte_t wr_data [8];
    i2c_req_pkg::word_addr_t addr;
    i2c_req_pkg::data_byte_t data;

    // bus monitor cleared by each request
    logic scl_q;
    logic sda_q;
    int   start_cnt;
    int   stop_cnt;
    int   addr_cnt;
    int   done_cnt;

    pullup (sda);

    i2c_master_top dut (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model u_slave (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .addr16    (bit_ctrl),
        .scl       (scl),
        .sda       (sda),
        .addr_stb  (addr_stb),
        .addr_byte (addr_byte),
        .addr_rs   (addr_rs)
    );

    always #50 dri_clk = ~dri_clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            start_cnt <= 0;
            stop_cnt  <= 0;
            addr_cnt  <= 0;
            done_cnt  <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (i2c_exec) begin
                start_cnt <= 0;
                stop_cnt  <= 0;
                addr_cnt  <= 0;
                done_cnt  <= 0;
            end else begin
                if (scl && scl_q && sda_q && !sda) begin
                    start_cnt <= start_cnt + 1;
                end
                if (scl && scl_q && !sda_q && sda) begin
                    stop_cnt <= stop_cnt + 1;
                end
                if (addr_stb) begin
                    addr_cnt <= addr_cnt + 1;
                end
                if (i2c_done) begin
                    done_cnt <= done_cnt + 1;
                end
            end
        end
    end

    // ********************
    // checks
    a_reset_idle: assert property (@(posedge dri_clk) disable iff (!rst_n)
        !started |-> (scl && sda && !i2c_done))
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: scl/sda/i2c_done expected 1/1/0 actual %b/%b/%b",
                     test_name, scl, sda, i2c_done);
        end

    a_read_data: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> i2c_data_r == exp_data)
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: i2c_data_r expected %h actual %h",
                     test_name, exp_data, i2c_data_r);
        end

    a_addr_frame: assert property (@(posedge dri_clk) disable iff (!rst_n)
        addr_stb |-> (addr_byte[7:1] == i2c_proto_pkg::SLAVE_ADDR) &&
                     (addr_byte[0] == (addr_rs ? i2c_req_pkg::RW_READ : i2c_req_pkg::RW_WRITE)))
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: address byte expected %h actual %h", test_name,
                     {i2c_proto_pkg::SLAVE_ADDR,
                      addr_rs ? i2c_req_pkg::RW_READ : i2c_req_pkg::RW_WRITE},
                     addr_byte);
        end

    a_addr_count: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> addr_cnt == (exp_rd ? 2 : 1))
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: address bytes expected %0d actual %0d",
                     test_name, exp_rd ? 2 : 1, addr_cnt);
        end

    a_start_count: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> start_cnt == (exp_rd ? 2 : 1))
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: start conditions expected %0d actual %0d",
                     test_name, exp_rd ? 2 : 1, start_cnt);
        end

    a_stop_count: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> stop_cnt == 1)
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: stop conditions expected 1 actual %0d", test_name, stop_cnt);
        end

    a_done_once: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> done_cnt == 0)
        else begin
            err_cnt = err_cnt + 1;
            $display("Error %s: i2c_done pulses expected 1 actual %0d", test_name, done_cnt + 1);
        end

    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else begin
            err_cnt = err_cnt + 1;
            $display("%s: i2c_done stayed high for more than one cycle", test_name);
        end

    // ********************
    // stimulus
    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!i2c_done && n < limit) begin
            @(posedge dri_clk);
            #DRV_DLY;
            n++;
        end
        if (!i2c_done) begin
            tmo_cnt = tmo_cnt + 1;
            $display("%s: no i2c_done within %0d cycles", test_name, limit);
        end
    endtask

    task automatic run_xfer(input string name, input logic rd, input logic wide,
                            input i2c_req_pkg::word_addr_t a,
                            input i2c_req_pkg::data_byte_t d,
                            input i2c_req_pkg::data_byte_t exp_val);
        if (tmo_cnt == 0) begin
            @(posedge dri_clk);
            #DRV_DLY;
            test_name  = name;
            exp_rd     = rd;
            exp_data   = exp_val;
            bit_ctrl   = wide;
            i2c_rh_wl  = rd;
            i2c_addr   = a;
            i2c_data_w = d;
            i2c_exec   = 1'b1;
            started    = 1'b1;
            @(posedge dri_clk);
            #DRV_DLY;
            i2c_exec = 1'b0;
            wait_done(DONE_LIMIT);
        end
    endtask

    initial begin
        dri_clk    = 1'b0;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        test_name  = "reset";
        started    = 1'b0;
        exp_rd     = 1'b0;
        exp_data   = '0;
        err_cnt    = 0;
        tmo_cnt    = 0;
        rng        = SEED;
        repeat (4) @(posedge dri_clk);
        #DRV_DLY;
        rst_n = 1'b1;
        repeat (3) @(posedge dri_clk);   // idle bus

        // 8-bit word address with each write read back at once
        for (int i = 0; i < 4; i++) begin
            rng  = lcg(rng);
            addr = {8'h00, rng[23:16]};
            data = rng[15:8];
            run_xfer("write8", 1'b0, 1'b0, addr, data, exp_data);   // read data holds
            run_xfer("read8", 1'b1, 1'b0, addr, 8'h00, data);
        end

        // 16-bit word address with distinct low bytes
        for (int i = 0; i < 8; i++) begin
            rng        = lcg(rng);
            wr_addr[i] = {rng[31:24], rng[20:16], 3'(i)};
            wr_data[i] = rng[15:8];
            run_xfer("write16", 1'b0, 1'b1, wr_addr[i], wr_data[i], exp_data);
        end
        for (int i = 0; i < 8; i++) begin
            run_xfer("read16", 1'b1, 1'b1, wr_addr[i], 8'h00, wr_data[i]);
        end

        repeat (3) @(posedge dri_clk);
        $display("errors: %0d check failures, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
i2c_proto_pkg.sv
i2c_req_pkg.sv
i2c_xfer_if.sv
i2c_seq_ctrl.sv
i2c_bit_engine.sv
i2c_byte_shifter.sv
i2c_master_top.sv
i2c_slave_model.sv
tb_i2c_master.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_i2c_master \
    -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_i2c_master > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
